//--- rtl/ninjin_pkg.sv
package ninjin_pkg;

  // ========================================
  // sizes
  // ========================================

  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 12;
  localparam int ID_WIDTH   = 4;
  localparam int LEN_WIDTH  = 8;
  localparam int NUM_BANK   = 4;
  localparam int BANK_DEPTH = 256;
  localparam int RSP_DEPTH  = 4;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // derived widths
  localparam int STRB_WIDTH    = DATA_WIDTH / 8;
  localparam int WORD_LSB      = $clog2(STRB_WIDTH);
  localparam int WADDR_WIDTH   = ADDR_WIDTH - WORD_LSB;
  localparam int BANK_WIDTH    = $clog2(NUM_BANK);
  localparam int ROW_WIDTH     = $clog2(BANK_DEPTH);
  localparam int RSP_PTR_WIDTH = $clog2(RSP_DEPTH);
  localparam int RSP_CNT_WIDTH = $clog2(RSP_DEPTH + 1);

  // ========================================
  // types
  // ========================================

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  // shared by AW and AR
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
    logic [2:0]            size;
    burst_t                burst;
  } axi_addr_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

  // word request, low address bits pick the bank
  typedef struct packed {
    logic                   we;
    logic [WADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]  wdata;
    logic [STRB_WIDTH-1:0]  strb;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

  // bank interleave
  function automatic logic [BANK_WIDTH-1:0] bank_of(input logic [WADDR_WIDTH-1:0] waddr);
    return BANK_WIDTH'(waddr % NUM_BANK);
  endfunction

  function automatic logic [ROW_WIDTH-1:0] row_of(input logic [WADDR_WIDTH-1:0] waddr);
    return ROW_WIDTH'(waddr / NUM_BANK);
  endfunction

endpackage

//--- rtl/ninjin_reg_slice.sv
module ninjin_reg_slice #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic xrst,
  input  T     in_data,
  input  logic in_valid,
  output logic in_ready,
  output T     out_data,
  output logic out_valid,
  input  logic out_ready
);

  T     main_data;
  T     skid_data;
  logic main_valid;
  logic skid_valid;

  assign in_ready  = !skid_valid;
  assign out_valid = main_valid;
  assign out_data  = main_data;

  // main stage moves when the output is free
  always_ff @(posedge clk) begin
    if (!xrst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_ready || !main_valid) begin
      main_valid <= skid_valid || in_valid;
      skid_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_ready || !main_valid) begin
      if (skid_valid) begin
        main_data <= skid_data;
      end else if (in_valid) begin
        main_data <= in_data;
      end
    end
    // output stalled, park the incoming beat
    if (in_valid && in_ready && main_valid && !out_ready) begin
      skid_data <= in_data;
    end
  end

endmodule

//--- rtl/ninjin_s_axi_gobou.sv
module ninjin_s_axi_gobou (
  input  logic                  clk,
  input  logic                  xrst,
  input  ninjin_pkg::axi_addr_t aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  ninjin_pkg::axi_w_t    w,
  input  logic                  w_valid,
  output logic                  w_ready,
  output ninjin_pkg::axi_b_t    b,
  output logic                  b_valid,
  input  logic                  b_ready,
  input  ninjin_pkg::axi_addr_t ar,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output ninjin_pkg::axi_r_t    r,
  output logic                  r_valid,
  input  logic                  r_ready,
  output ninjin_pkg::mem_req_t  req,
  output logic                  req_valid,
  input  logic                  req_ready,
  input  ninjin_pkg::mem_rsp_t  rsp,
  input  logic                  rsp_valid,
  output logic                  rsp_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_WRESP,
    ST_READ
  } state_t;

  state_t                               state;
  ninjin_pkg::axi_addr_t                addr_sel;
  logic [ninjin_pkg::ID_WIDTH-1:0]      id_q;
  logic [ninjin_pkg::LEN_WIDTH-1:0]     len_q;
  ninjin_pkg::burst_t                   burst_q;
  logic [ninjin_pkg::WADDR_WIDTH-1:0]   addr_q;
  logic [ninjin_pkg::WADDR_WIDTH-1:0]   addr_nxt;
  logic [ninjin_pkg::WADDR_WIDTH-1:0]   wrap_mask;
  logic [ninjin_pkg::LEN_WIDTH:0]       req_cnt;
  logic [ninjin_pkg::LEN_WIDTH-1:0]     rsp_cnt;
  logic                                 aw_hs;
  logic                                 ar_hs;
  logic                                 w_hs;
  logic                                 b_hs;
  logic                                 r_hs;
  logic                                 req_hs;
  logic                                 rd_issue_done;

  // ========================================
  // address channels
  // ========================================

  // write wins when both arrive together
  assign aw_ready = (state == ST_IDLE);
  assign ar_ready = (state == ST_IDLE) && !aw_valid;
  assign aw_hs    = aw_valid && aw_ready;
  assign ar_hs    = ar_valid && ar_ready;
  assign addr_sel = aw_valid ? aw : ar;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (aw_hs) begin
            state <= ST_WRITE;
          end else if (ar_hs) begin
            state <= ST_READ;
          end
        end
        ST_WRITE: begin
          if (w_hs && w.last) begin
            state <= ST_WRESP;
          end
        end
        ST_WRESP: begin
          if (b_hs) begin
            state <= ST_IDLE;
          end
        end
        ST_READ: begin
          if (r_hs && r.last) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // burst address generation
  // wrap block is len+1 words, aligned
  assign wrap_mask = {{(ninjin_pkg::WADDR_WIDTH-4){1'b0}}, len_q[3:0]};

  always_comb begin
    case (burst_q)
      ninjin_pkg::FIXED: addr_nxt = addr_q;
      ninjin_pkg::WRAP:  addr_nxt = (addr_q & ~wrap_mask) | ((addr_q + 1'b1) & wrap_mask);
      default:           addr_nxt = addr_q + 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (aw_hs || ar_hs) begin
      id_q    <= addr_sel.id;
      len_q   <= addr_sel.len;
      burst_q <= addr_sel.burst;
      addr_q  <= addr_sel.addr[ninjin_pkg::ADDR_WIDTH-1:ninjin_pkg::WORD_LSB];
    end else if (req_hs) begin
      addr_q <= addr_nxt;
    end
  end

  // issued requests and returned beats run apart
  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_cnt <= '0;
      rsp_cnt <= '0;
    end else if (aw_hs || ar_hs) begin
      req_cnt <= '0;
      rsp_cnt <= '0;
    end else begin
      if (req_hs) begin
        req_cnt <= req_cnt + 1'b1;
      end
      if (r_hs) begin
        rsp_cnt <= rsp_cnt + 1'b1;
      end
    end
  end

  // ========================================
  // word requests
  // ========================================

  assign rd_issue_done = req_cnt > {1'b0, len_q};

  // W beats pass straight through as writes
  assign w_ready   = (state == ST_WRITE) && req_ready;
  assign w_hs      = w_valid && w_ready;
  assign req_valid = ((state == ST_WRITE) && w_valid)
                   || ((state == ST_READ) && !rd_issue_done);
  assign req_hs    = req_valid && req_ready;

  assign req.we    = (state == ST_WRITE);
  assign req.addr  = addr_q;
  assign req.wdata = w.data;
  assign req.strb  = (state == ST_WRITE) ? w.strb : '0;

  // ========================================
  // responses
  // ========================================

  assign b_valid = (state == ST_WRESP);
  assign b_hs    = b_valid && b_ready;
  assign b.id    = id_q;
  assign b.resp  = ninjin_pkg::RESP_OKAY;

  // R is the merger head plus latched id
  assign r_valid   = (state == ST_READ) && rsp_valid;
  assign rsp_ready = (state == ST_READ) && r_ready;
  assign r_hs      = r_valid && r_ready;
  assign r.id      = id_q;
  assign r.data    = rsp.rdata;
  assign r.resp    = ninjin_pkg::RESP_OKAY;
  assign r.last    = (rsp_cnt == len_q);

endmodule

//--- rtl/ninjin_bank_router.sv
module ninjin_bank_router (
  input  logic                                              clk,
  input  logic                                              xrst,
  input  ninjin_pkg::mem_req_t                              req,
  input  logic                                              req_valid,
  output logic                                              req_ready,
  output ninjin_pkg::mem_req_t [ninjin_pkg::NUM_BANK-1:0]   bank_req,
  output logic [ninjin_pkg::NUM_BANK-1:0]                   bank_valid,
  input  logic                                              pop
);

  logic [ninjin_pkg::BANK_WIDTH-1:0]    bank_sel;
  logic [ninjin_pkg::ROW_WIDTH-1:0]     row;
  logic [ninjin_pkg::RSP_CNT_WIDTH-1:0] inflight;
  logic                                 rd_issue;

  assign bank_sel = ninjin_pkg::bank_of(req.addr);
  assign row      = ninjin_pkg::row_of(req.addr);

  // reads wait for a free merger slot
  assign req_ready = req.we || (int'(inflight) < ninjin_pkg::RSP_DEPTH);
  assign rd_issue  = req_valid && req_ready && !req.we;

  always_comb begin
    for (int i = 0; i < ninjin_pkg::NUM_BANK; i++) begin
      bank_req[i]                                = req;
      bank_req[i].addr                           = '0;
      bank_req[i].addr[ninjin_pkg::ROW_WIDTH-1:0] = row;
      bank_valid[i] = req_valid && req_ready && (int'(bank_sel) == i);
    end
  end

  // read credits, returned by merger pops
  always_ff @(posedge clk) begin
    if (!xrst) begin
      inflight <= '0;
    end else if (rd_issue && !pop) begin
      inflight <= inflight + 1'b1;
    end else if (!rd_issue && pop) begin
      inflight <= inflight - 1'b1;
    end
  end

endmodule

//--- rtl/ninjin_mem_bank.sv
module ninjin_mem_bank (
  input  logic                 clk,
  input  ninjin_pkg::mem_req_t req,
  input  logic                 valid,
  output ninjin_pkg::mem_rsp_t rdata,
  output logic                 rvalid
);

  logic [ninjin_pkg::DATA_WIDTH-1:0] mem [ninjin_pkg::BANK_DEPTH];
  logic [ninjin_pkg::ROW_WIDTH-1:0]  row;

  assign row = req.addr[ninjin_pkg::ROW_WIDTH-1:0];

  // byte lanes under strobe
  always_ff @(posedge clk) begin
    if (valid && req.we) begin
      for (int i = 0; i < ninjin_pkg::STRB_WIDTH; i++) begin
        if (req.strb[i]) begin
          mem[row][i*8 +: 8] <= req.wdata[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid && !req.we) begin
      rdata.rdata <= mem[row];
    end
  end

  // one-cycle pulse, data valid alongside
  always_ff @(posedge clk) begin
    rvalid <= valid && !req.we;
  end

endmodule

//--- rtl/ninjin_rsp_merge.sv
module ninjin_rsp_merge (
  input  logic                                            clk,
  input  logic                                            xrst,
  input  ninjin_pkg::mem_rsp_t [ninjin_pkg::NUM_BANK-1:0] bank_rdata,
  input  logic [ninjin_pkg::NUM_BANK-1:0]                 bank_rvalid,
  output ninjin_pkg::mem_rsp_t                            rsp,
  output logic                                            rsp_valid,
  input  logic                                            rsp_ready,
  output logic                                            pop
);

  ninjin_pkg::mem_rsp_t                 fifo [ninjin_pkg::RSP_DEPTH];
  ninjin_pkg::mem_rsp_t                 sel_data;
  logic                                 push;
  logic [ninjin_pkg::RSP_PTR_WIDTH-1:0] wr_ptr;
  logic [ninjin_pkg::RSP_PTR_WIDTH-1:0] rd_ptr;
  logic [ninjin_pkg::RSP_CNT_WIDTH-1:0] count;

  // at most one bank returns per cycle
  always_comb begin
    sel_data = '0;
    for (int i = 0; i < ninjin_pkg::NUM_BANK; i++) begin
      if (bank_rvalid[i]) begin
        sel_data = bank_rdata[i];
      end
    end
  end

  assign push      = |bank_rvalid;
  assign rsp_valid = (count != '0);
  assign rsp       = fifo[rd_ptr];
  assign pop       = rsp_valid && rsp_ready;

  // ========================================
  // read data FIFO
  // ========================================

  always_ff @(posedge clk) begin
    if (push) begin
      fifo[wr_ptr] <= sel_data;
    end
  end

  // router credits keep the count within depth
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- rtl/ninjin_top.sv
module ninjin_top (
  input  logic                  clk,
  input  logic                  xrst,
  input  ninjin_pkg::axi_addr_t aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  ninjin_pkg::axi_w_t    w,
  input  logic                  w_valid,
  output logic                  w_ready,
  output ninjin_pkg::axi_b_t    b,
  output logic                  b_valid,
  input  logic                  b_ready,
  input  ninjin_pkg::axi_addr_t ar,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output ninjin_pkg::axi_r_t    r,
  output logic                  r_valid,
  input  logic                  r_ready
);

  ninjin_pkg::axi_addr_t                          aw_s;
  logic                                           aw_s_valid;
  logic                                           aw_s_ready;
  ninjin_pkg::axi_w_t                             w_s;
  logic                                           w_s_valid;
  logic                                           w_s_ready;
  ninjin_pkg::axi_addr_t                          ar_s;
  logic                                           ar_s_valid;
  logic                                           ar_s_ready;
  ninjin_pkg::mem_req_t                           req;
  logic                                           req_valid;
  logic                                           req_ready;
  ninjin_pkg::mem_req_t [ninjin_pkg::NUM_BANK-1:0] bank_req;
  logic [ninjin_pkg::NUM_BANK-1:0]                bank_valid;
  ninjin_pkg::mem_rsp_t [ninjin_pkg::NUM_BANK-1:0] bank_rdata;
  logic [ninjin_pkg::NUM_BANK-1:0]                bank_rvalid;
  ninjin_pkg::mem_rsp_t                           rsp;
  logic                                           rsp_valid;
  logic                                           rsp_ready;
  logic                                           pop;

  // ========================================
  // input slices
  // ========================================

  ninjin_reg_slice #(.T(ninjin_pkg::axi_addr_t)) i_aw_slice (
    .clk, .xrst,
    .in_data(aw), .in_valid(aw_valid), .in_ready(aw_ready),
    .out_data(aw_s), .out_valid(aw_s_valid), .out_ready(aw_s_ready)
  );

  ninjin_reg_slice #(.T(ninjin_pkg::axi_w_t)) i_w_slice (
    .clk, .xrst,
    .in_data(w), .in_valid(w_valid), .in_ready(w_ready),
    .out_data(w_s), .out_valid(w_s_valid), .out_ready(w_s_ready)
  );

  ninjin_reg_slice #(.T(ninjin_pkg::axi_addr_t)) i_ar_slice (
    .clk, .xrst,
    .in_data(ar), .in_valid(ar_valid), .in_ready(ar_ready),
    .out_data(ar_s), .out_valid(ar_s_valid), .out_ready(ar_s_ready)
  );

  // ========================================
  // slave, router, banks, merger
  // ========================================

  ninjin_s_axi_gobou i_slave (
    .clk, .xrst,
    .aw(aw_s), .aw_valid(aw_s_valid), .aw_ready(aw_s_ready),
    .w(w_s), .w_valid(w_s_valid), .w_ready(w_s_ready),
    .b, .b_valid, .b_ready,
    .ar(ar_s), .ar_valid(ar_s_valid), .ar_ready(ar_s_ready),
    .r, .r_valid, .r_ready,
    .req, .req_valid, .req_ready,
    .rsp, .rsp_valid, .rsp_ready
  );

  ninjin_bank_router i_router (
    .clk, .xrst,
    .req, .req_valid, .req_ready,
    .bank_req, .bank_valid,
    .pop
  );

  for (genvar i = 0; i < ninjin_pkg::NUM_BANK; i++) begin : g_bank
    ninjin_mem_bank i_mem_bank (
      .clk,
      .req(bank_req[i]),
      .valid(bank_valid[i]),
      .rdata(bank_rdata[i]),
      .rvalid(bank_rvalid[i])
    );
  end

  ninjin_rsp_merge i_merge (
    .clk, .xrst,
    .bank_rdata, .bank_rvalid,
    .rsp, .rsp_valid, .rsp_ready,
    .pop
  );

endmodule

//--- test/ninjin_top_sva.sv
module ninjin_top_sva (
  input logic               clk,
  input logic               xrst,
  input logic               aw_valid,
  input logic               aw_ready,
  input logic               ar_valid,
  input logic               ar_ready,
  input ninjin_pkg::axi_b_t b,
  input logic               b_valid,
  input logic               b_ready,
  input ninjin_pkg::axi_r_t r,
  input logic               r_valid,
  input logic               r_ready,
  input logic               req_valid
);

  // number of failed assertions so far
  int   fail_count = 0;
  logic txn_open;

  // open from the address handshake to the last response
  always_ff @(posedge clk) begin
    if (!xrst) begin
      txn_open <= 1'b0;
    end else if ((aw_valid && aw_ready) || (ar_valid && ar_ready)) begin
      txn_open <= 1'b1;
    end else if ((b_valid && b_ready) || (r_valid && r_ready && r.last)) begin
      txn_open <= 1'b0;
    end
  end

  // B and R hold while stalled
  a_hold_b: assert property (@(posedge clk) disable iff (!xrst)
    b_valid && !b_ready |=> b_valid && $stable(b))
  else begin
    fail_count++;
    $error("B changed while bready was low");
  end

  a_hold_r: assert property (@(posedge clk) disable iff (!xrst)
    r_valid && !r_ready |=> r_valid && $stable(r))
  else begin
    fail_count++;
    $error("R changed while rready was low");
  end

  // requests only inside an accepted transaction
  a_idle_no_req: assert property (@(posedge clk) disable iff (!xrst)
    req_valid |-> txn_open)
  else begin
    fail_count++;
    $error("word request issued while idle");
  end

  a_one_resp: assert property (@(posedge clk) disable iff (!xrst)
    !(b_valid && r_valid))
  else begin
    fail_count++;
    $error("bvalid and rvalid high together");
  end

endmodule

bind ninjin_s_axi_gobou ninjin_top_sva i_sva (
  .clk(clk),
  .xrst(xrst),
  .aw_valid(aw_valid),
  .aw_ready(aw_ready),
  .ar_valid(ar_valid),
  .ar_ready(ar_ready),
  .b(b),
  .b_valid(b_valid),
  .b_ready(b_ready),
  .r(r),
  .r_valid(r_valid),
  .r_ready(r_ready),
  .req_valid(req_valid)
);

//--- test/ninjin_top_tb.sv
module ninjin_top_tb;

  logic                  clk;
  logic                  xrst;
  ninjin_pkg::axi_addr_t aw;
  logic                  aw_valid;
  logic                  aw_ready;
  ninjin_pkg::axi_w_t    w;
  logic                  w_valid;
  logic                  w_ready;
  ninjin_pkg::axi_b_t    b;
  logic                  b_valid;
  logic                  b_ready;
  ninjin_pkg::axi_addr_t ar;
  logic                  ar_valid;
  logic                  ar_ready;
  ninjin_pkg::axi_r_t    r;
  logic                  r_valid;
  logic                  r_ready;

  typedef struct packed {
    logic                              is_write;
    logic [ninjin_pkg::ID_WIDTH-1:0]   id;
    logic [ninjin_pkg::ADDR_WIDTH-1:0] addr;
    logic [ninjin_pkg::LEN_WIDTH-1:0]  len;
    ninjin_pkg::burst_t                burst;
    logic [ninjin_pkg::STRB_WIDTH-1:0] strb;
    logic [31:0]                       seed;
  } txn_t;

  txn_t        txns [$];
  logic [31:0] ref_mem [ninjin_pkg::NUM_BANK * ninjin_pkg::BANK_DEPTH];
  logic [31:0] lfsr = 32'h700e;
  int          wait_limit = 1000;

  ninjin_top i_ninjin_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ========================================
  // helpers
  // ========================================

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic random_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  // word address of the following beat
  function automatic int next_word(input int wa, input int len, input ninjin_pkg::burst_t burst);
    int base;
    base = wa - (wa % (len + 1));
    case (burst)
      ninjin_pkg::FIXED: return wa;
      ninjin_pkg::WRAP:  return base + ((wa - base + 1) % (len + 1));
      default:           return (wa + 1) % (ninjin_pkg::NUM_BANK * ninjin_pkg::BANK_DEPTH);
    endcase
  endfunction

  function automatic logic [31:0] beat_data(input logic [31:0] seed, input int beat);
    return seed + beat * 32'h0103_0507;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_run($sformatf("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_b(input ninjin_pkg::axi_b_t got, input ninjin_pkg::axi_b_t exp);
    if (got.id !== exp.id) report_mismatch("b.id", 32'(got.id), 32'(exp.id));
    if (got.resp !== exp.resp) report_mismatch("b.resp", 32'(got.resp), 32'(exp.resp));
  endtask

  task automatic check_r(input ninjin_pkg::axi_r_t got, input ninjin_pkg::axi_r_t exp);
    if (got.id !== exp.id) report_mismatch("r.id", 32'(got.id), 32'(exp.id));
    if (got.data !== exp.data) report_mismatch("r.data", got.data, exp.data);
    if (got.resp !== exp.resp) report_mismatch("r.resp", 32'(got.resp), 32'(exp.resp));
    if (got.last !== exp.last) report_mismatch("r.last", 32'(got.last), 32'(exp.last));
  endtask

  task automatic expect_quiet(input string where);
    @(negedge clk);
    if (b_valid !== 1'b0 || r_valid !== 1'b0) begin
      stop_run($sformatf("response valid raised during %s", where));
    end
    @(posedge clk);
  endtask

  task automatic add_txn(input logic is_write, input int id, input int addr, input int len,
                         input ninjin_pkg::burst_t burst, input int strb, input int seed);
    txn_t t;
    t.is_write = is_write;
    t.id       = id[ninjin_pkg::ID_WIDTH-1:0];
    t.addr     = addr[ninjin_pkg::ADDR_WIDTH-1:0];
    t.len      = len[ninjin_pkg::LEN_WIDTH-1:0];
    t.burst    = burst;
    t.strb     = strb[ninjin_pkg::STRB_WIDTH-1:0];
    t.seed     = seed;
    txns.push_back(t);
  endtask

  // ========================================
  // channel tasks are entered right after a rising edge
  // ========================================

  task automatic send_addr(input ninjin_pkg::axi_addr_t a, input logic is_write);
    int cycles;
    cycles = 0;
    if (is_write) begin
      aw       <= a;
      aw_valid <= 1'b1;
    end else begin
      ar       <= a;
      ar_valid <= 1'b1;
    end
    forever begin
      @(negedge clk);
      if (b_valid || r_valid) stop_run("response seen before the address handshake");
      if (is_write ? aw_ready : ar_ready) break;
      cycles++;
      if (cycles > wait_limit) stop_run("timeout waiting for an address handshake");
    end
    @(posedge clk);
    aw_valid <= 1'b0;
    ar_valid <= 1'b0;
  endtask

  task automatic send_w(input txn_t t);
    ninjin_pkg::axi_w_t beat_w;
    int                 wa;
    int                 cycles;
    wa = int'(t.addr[ninjin_pkg::ADDR_WIDTH-1:2]);
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      beat_w.data = beat_data(t.seed, beat);
      beat_w.strb = t.strb;
      beat_w.last = (beat == int'(t.len));
      w       <= beat_w;
      w_valid <= 1'b1;
      cycles = 0;
      forever begin
        @(negedge clk);
        if (w_ready) break;
        cycles++;
        if (cycles > wait_limit) stop_run("timeout waiting for wready");
      end
      @(posedge clk);
      // update the model per byte lane under strobe
      for (int i = 0; i < ninjin_pkg::STRB_WIDTH; i++) begin
        if (t.strb[i]) ref_mem[wa][i*8 +: 8] = beat_w.data[i*8 +: 8];
      end
      wa = next_word(wa, int'(t.len), t.burst);
    end
    w_valid <= 1'b0;
  endtask

  task automatic wait_b(input ninjin_pkg::axi_b_t exp);
    int cycles;
    cycles = 0;
    forever begin
      b_ready <= random_bit();
      @(negedge clk);
      if (b_valid && b_ready) break;
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit) stop_run("timeout waiting for the write response");
    end
    check_b(b, exp);
    @(posedge clk);
    b_ready <= 1'b0;
  endtask

  task automatic read_beats(input txn_t t);
    ninjin_pkg::axi_r_t exp_r;
    int                 wa;
    int                 beat;
    int                 cycles;
    wa         = int'(t.addr[ninjin_pkg::ADDR_WIDTH-1:2]);
    beat       = 0;
    cycles     = 0;
    exp_r.id   = t.id;
    exp_r.resp = ninjin_pkg::RESP_OKAY;
    while (beat <= int'(t.len)) begin
      r_ready <= random_bit();
      @(negedge clk);
      if (r_valid && r_ready) begin
        exp_r.data = ref_mem[wa];
        exp_r.last = (beat == int'(t.len));
        check_r(r, exp_r);
        wa = next_word(wa, int'(t.len), t.burst);
        beat++;
        cycles = 0;
      end else begin
        cycles++;
        if (cycles > wait_limit) stop_run("timeout waiting for a read beat");
      end
      @(posedge clk);
    end
    r_ready <= 1'b0;
  endtask

  task automatic run_txn(input txn_t t);
    ninjin_pkg::axi_addr_t a;
    ninjin_pkg::axi_b_t    exp_b;
    a.id       = t.id;
    a.addr     = t.addr;
    a.len      = t.len;
    a.size     = 3'd2;
    a.burst    = t.burst;
    exp_b.id   = t.id;
    exp_b.resp = ninjin_pkg::RESP_OKAY;
    send_addr(a, t.is_write);
    if (t.is_write) begin
      send_w(t);
      wait_b(exp_b);
    end else begin
      read_beats(t);
    end
  endtask

  // ========================================
  // transaction table and main sequence
  // ========================================

  task automatic load_table();
    // kind, id, byte address, len, burst, strobe, data seed
    add_txn(1'b1, 1, 12'h000, 15, ninjin_pkg::INCR, 4'hf, 32'h1000_0000);
    add_txn(1'b0, 2, 12'h000, 15, ninjin_pkg::INCR, 4'h0, 0);
    // wrap blocks entered mid-block
    add_txn(1'b1, 3, 12'h048, 3, ninjin_pkg::WRAP, 4'hf, 32'h2000_0000);
    add_txn(1'b0, 4, 12'h048, 3, ninjin_pkg::WRAP, 4'h0, 0);
    add_txn(1'b1, 5, 12'h0a8, 7, ninjin_pkg::WRAP, 4'hf, 32'h3000_0000);
    add_txn(1'b0, 6, 12'h0a8, 7, ninjin_pkg::WRAP, 4'h0, 0);
    add_txn(1'b0, 7, 12'h0b4, 7, ninjin_pkg::WRAP, 4'h0, 0);
    add_txn(1'b1, 8, 12'h100, 4, ninjin_pkg::FIXED, 4'hf, 32'h4000_0000);
    add_txn(1'b0, 9, 12'h100, 0, ninjin_pkg::INCR, 4'h0, 0);
    // partial strobes over the first burst
    add_txn(1'b1, 10, 12'h004, 3, ninjin_pkg::INCR, 4'h5, 32'h5a5a_0000);
    add_txn(1'b1, 11, 12'h008, 0, ninjin_pkg::INCR, 4'h8, 32'hc300_0000);
    add_txn(1'b0, 12, 12'h000, 7, ninjin_pkg::INCR, 4'h0, 0);
    add_txn(1'b1, 13, 12'h200, 63, ninjin_pkg::INCR, 4'hf, 32'h6000_0000);
    add_txn(1'b0, 14, 12'h200, 63, ninjin_pkg::INCR, 4'h0, 0);
  endtask

  initial begin
    xrst     = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    load_table();

    @(posedge clk);
    repeat (15) expect_quiet("reset");
    xrst <= 1'b1;
    repeat (4) expect_quiet("the first cycles after reset");
    @(negedge clk);
    if (!aw_ready || !ar_ready) stop_run("address channels not ready after reset");
    @(posedge clk);

    foreach (txns[i]) begin
      run_txn(txns[i]);
    end
    repeat (4) expect_quiet("the idle tail");

    if (i_ninjin_top.i_slave.i_sva.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      stop_run("protocol assertion failed during the run");
    end
  end

endmodule

//--- build.f
rtl/ninjin_pkg.sv
rtl/ninjin_reg_slice.sv
rtl/ninjin_s_axi_gobou.sv
rtl/ninjin_bank_router.sv
rtl/ninjin_mem_bank.sv
rtl/ninjin_rsp_merge.sv
rtl/ninjin_top.sv
test/ninjin_top_sva.sv
test/ninjin_top_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module ninjin_top_tb \
  -f build.f -o ninjin_sim
./obj_dir/ninjin_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "run passed"
else
  echo "run failed"
  exit 1
fi
